/* design/wfd_pkg.sv */
package wfd_pkg;

  ////////////////////////////////////////////////////////////
  // data widths
  typedef logic [11:0] sample_t;          // raw adc sample
  typedef logic [12:0] tagged_sample_t;   // {ovr, sample}
  typedef logic [31:0] word_t;            // memory and stream word
  typedef logic [19:0] fill_num_t;        // accepted trigger count
  typedef logic [11:0] chan_tag_t;        // channel id for the header
  typedef logic [15:0] word_cnt_t;        // words per waveform
  typedef logic [7:0]  axil_addr_t;       // register byte address

  ////////////////////////////////////////////////////////////
  // register map
  localparam axil_addr_t REG_CTRL      = 8'h00;  // [0] arm, [1] start readout
  localparam axil_addr_t REG_NUM_WORDS = 8'h04;
  localparam axil_addr_t REG_CHAN_TAG  = 8'h08;
  localparam axil_addr_t REG_STATUS    = 8'h0C;  // read only
  localparam axil_addr_t REG_PEEK_ADDR = 8'h10;
  localparam axil_addr_t REG_PEEK_DATA = 8'h14;  // read only, memory word

  localparam logic [1:0] RESP_OKAY = 2'b00;

  ////////////////////////////////////////////////////////////
  // bundles
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    word_t      wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic      arm;           // triggers accepted when set
    word_cnt_t num_words;     // 1 .. 2**MEM_AW
    chan_tag_t channel_tag;
  } acq_cfg_t;

  typedef struct packed {
    logic      capturing;
    logic      acq_done;
    fill_num_t fill_num;
  } acq_status_t;

  typedef struct packed {
    word_t tdata;
    logic  tlast;
  } stream_t;

endpackage

/* design/wfd_regs.sv */
module wfd_regs #(
  parameter int MEM_AW = 10
) (
  input  logic                clk125,
  input  logic                rst_n,
  input  wfd_pkg::axil_req_t  axil_req,
  input  wfd_pkg::acq_status_t acq_status,
  input  logic                readout_busy,
  input  logic                peek_gnt,
  input  logic                peek_rvalid,
  input  wfd_pkg::word_t      peek_rdata,
  output wfd_pkg::axil_rsp_t  axil_rsp,
  output wfd_pkg::acq_cfg_t   acq_cfg,
  output logic                readout_start,
  output logic                peek_req,
  output logic [MEM_AW-1:0]   peek_addr
);

  logic           awready_q;    // shared aw/w ready pulse
  logic           bvalid_q;
  logic           arready_q;
  logic           rvalid_q;     // registered read data pending
  logic           peek_wait;    // granted peek, data due next cycle
  logic           wr_fire;
  logic           rd_fire;
  logic           peek_done;    // peek data on the bus this cycle
  wfd_pkg::word_t rdata_q;
  wfd_pkg::word_t rd_mux;

  assign wr_fire   = awready_q && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire   = arready_q && axil_req.arvalid;
  assign peek_done = peek_wait && peek_rvalid;

  ////////////////////////////////////////////////////////////
  // write channel and config registers
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      awready_q           <= 1'b0;
      bvalid_q            <= 1'b0;
      readout_start       <= 1'b0;
      acq_cfg.arm         <= 1'b0;
      acq_cfg.num_words   <= 16'd1;   // smallest legal waveform
      acq_cfg.channel_tag <= '0;
      peek_addr           <= '0;
    end else begin
      awready_q     <= axil_req.awvalid && axil_req.wvalid && !bvalid_q && !awready_q;
      readout_start <= 1'b0;                 // single-cycle pulse
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        case (axil_req.awaddr)
          wfd_pkg::REG_CTRL: begin
            acq_cfg.arm   <= axil_req.wdata[0];
            readout_start <= axil_req.wdata[1];  // self-clearing bit
          end
          wfd_pkg::REG_NUM_WORDS: acq_cfg.num_words   <= axil_req.wdata[15:0];
          wfd_pkg::REG_CHAN_TAG:  acq_cfg.channel_tag <= axil_req.wdata[11:0];
          wfd_pkg::REG_PEEK_ADDR: peek_addr           <= axil_req.wdata[MEM_AW-1:0];
          default: ;                             // writes elsewhere are dropped
        endcase
      end else if (bvalid_q && axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read channel
  always_comb begin
    case (axil_req.araddr)
      wfd_pkg::REG_CTRL:      rd_mux = {31'd0, acq_cfg.arm};
      wfd_pkg::REG_NUM_WORDS: rd_mux = {16'd0, acq_cfg.num_words};
      wfd_pkg::REG_CHAN_TAG:  rd_mux = {20'd0, acq_cfg.channel_tag};
      wfd_pkg::REG_STATUS:    rd_mux = {acq_status.fill_num, 9'd0, readout_busy,
                                        acq_status.acq_done, acq_status.capturing};
      wfd_pkg::REG_PEEK_ADDR: rd_mux = {{(32-MEM_AW){1'b0}}, peek_addr};
      default:                rd_mux = '0;  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      peek_req  <= 1'b0;
      peek_wait <= 1'b0;
    end else begin
      arready_q <= axil_req.arvalid && !arready_q && !rvalid_q && !peek_req && !peek_wait;
      if (rd_fire) begin
        if (axil_req.araddr == wfd_pkg::REG_PEEK_DATA) begin
          peek_req <= 1'b1;                  // hold until the arbiter grants
        end else begin
          rvalid_q <= 1'b1;
        end
      end
      if (peek_req && peek_gnt) begin
        peek_req  <= 1'b0;
        peek_wait <= 1'b1;
      end
      if (peek_done) begin
        peek_wait <= 1'b0;
        rvalid_q  <= !axil_req.rready;       // keep it only if not taken right away
      end else if (rvalid_q && axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk125) begin
    if (rd_fire) begin
      rdata_q <= rd_mux;
    end else if (peek_done) begin
      rdata_q <= peek_rdata;                 // memory output is not held
    end
  end

  always_comb begin
    axil_rsp.awready = awready_q;
    axil_rsp.wready  = awready_q;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = wfd_pkg::RESP_OKAY;
    axil_rsp.arready = arready_q;
    axil_rsp.rvalid  = rvalid_q || peek_done;
    axil_rsp.rdata   = rvalid_q ? rdata_q : peek_rdata;
    axil_rsp.rresp   = wfd_pkg::RESP_OKAY;
  end

endmodule

/* design/wfd_acq.sv */
module wfd_acq #(
  parameter int MEM_AW = 10
) (
  input  logic                 clk125,
  input  logic                 rst_n,
  input  wfd_pkg::acq_cfg_t    acq_cfg,
  input  logic                 readout_busy,
  input  logic                 acq_trig,
  input  wfd_pkg::sample_t     adc_sample,
  input  logic                 adc_ovr,
  input  logic                 wr_gnt,
  output wfd_pkg::acq_status_t acq_status,
  output logic                 acq_done,
  output logic                 wr_req,
  output logic [MEM_AW-1:0]    wr_addr,
  output wfd_pkg::word_t       wr_data
);

  typedef enum logic [1:0] {ACQ_IDLE, ACQ_CAPTURE, ACQ_DONE} acq_state_t;

  acq_state_t                state;
  logic                      trig_q;       // acq_trig at the previous edge
  logic                      trig_ok;      // accepted rising edge
  logic                      odd_phase;    // next sample completes a word
  logic                      more_words;   // words still to issue
  wfd_pkg::tagged_sample_t   even_q;
  wfd_pkg::word_cnt_t        word_cnt;     // words issued this capture
  wfd_pkg::fill_num_t        fill_num;

  assign trig_ok = acq_trig && !trig_q && acq_cfg.arm && (state != ACQ_CAPTURE)
                   && !readout_busy;
  assign more_words = (word_cnt != acq_cfg.num_words);

  ////////////////////////////////////////////////////////////
  // capture FSM
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      state     <= ACQ_IDLE;
      trig_q    <= 1'b0;
      odd_phase <= 1'b0;
      word_cnt  <= '0;
      fill_num  <= '0;
      acq_done  <= 1'b0;
      wr_req    <= 1'b0;
    end else begin
      trig_q <= acq_trig;
      if (wr_req && wr_gnt) wr_req <= 1'b0;  // acq port always wins
      case (state)
        ACQ_CAPTURE: begin
          odd_phase <= !odd_phase;
          if (odd_phase && more_words) begin
            wr_req   <= 1'b1;
            word_cnt <= word_cnt + 16'd1;
          end
          if (wr_req && wr_gnt && !more_words) begin
            state    <= ACQ_DONE;               // last word is in memory now
            acq_done <= 1'b1;
          end
        end
        default: begin                          // idle and done both rearm
          if (trig_ok) begin
            state     <= ACQ_CAPTURE;
            fill_num  <= fill_num + 20'd1;
            word_cnt  <= '0;
            odd_phase <= 1'b1;                  // trigger sample is the even one
            acq_done  <= 1'b0;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // sample pairing
  always_ff @(posedge clk125) begin
    if (trig_ok || (state == ACQ_CAPTURE && !odd_phase)) begin
      even_q <= {adc_ovr, adc_sample};
    end
    if (state == ACQ_CAPTURE && odd_phase && more_words) begin
      wr_data <= {fill_num[5:0], adc_ovr, adc_sample, even_q};  // odd over even
      wr_addr <= word_cnt[MEM_AW-1:0];
    end
  end

  assign acq_status.capturing = (state == ACQ_CAPTURE);
  assign acq_status.acq_done  = acq_done;
  assign acq_status.fill_num  = fill_num;

endmodule

/* design/wfd_readout.sv */
module wfd_readout #(
  parameter int MEM_AW = 10
) (
  input  logic               clk125,
  input  logic               rst_n,
  input  wfd_pkg::acq_cfg_t  acq_cfg,
  input  logic               acq_done,
  input  logic               readout_start,
  input  logic               readout_pause,
  input  logic               rd_gnt,
  input  logic               rd_rvalid,
  input  wfd_pkg::word_t     rd_rdata,
  input  logic               tx_tready,
  output logic               readout_busy,
  output logic               rd_req,
  output logic [MEM_AW-1:0]  rd_addr,
  output wfd_pkg::stream_t   tx,
  output logic               tx_tvalid
);

  typedef enum logic [1:0] {RD_IDLE, RD_HEADER, RD_DATA} rd_state_t;

  rd_state_t          state;
  logic               pause_s1;
  logic               pause_s2;     // synchronized pause
  logic               done_q;       // acq_done delayed, for edge detect
  wfd_pkg::fill_num_t fill_cnt;     // tracks the capture fill number
  wfd_pkg::word_cnt_t issue_cnt;    // reads granted
  wfd_pkg::word_cnt_t recv_cnt;     // read data returned
  wfd_pkg::stream_t   obuf [2];
  wfd_pkg::stream_t   push_word;
  logic               wr_ptr;
  logic               rd_ptr;
  logic [1:0]         count;        // buffered words
  logic [1:0]         inflight;     // reads granted, data not back yet
  logic               push;
  logic               pop;

  ////////////////////////////////////////////////////////////
  // output buffer and stream handshake
  assign tx_tvalid    = (count != 2'd0) && !pause_s2;
  assign tx           = obuf[rd_ptr];
  assign pop          = tx_tvalid && tx_tready;
  assign push         = (state == RD_HEADER) || rd_rvalid;
  assign readout_busy = (state != RD_IDLE);
  assign rd_addr      = issue_cnt[MEM_AW-1:0];
  assign rd_req       = (state == RD_DATA) && (issue_cnt != acq_cfg.num_words)
                        && (3'(count) + 3'(inflight) < 3'd2);  // room for the data

  always_comb begin
    if (state == RD_HEADER) begin
      push_word.tdata = {acq_cfg.channel_tag, fill_cnt};
      push_word.tlast = 1'b0;
    end else begin
      push_word.tdata = rd_rdata;
      push_word.tlast = (recv_cnt == acq_cfg.num_words - 16'd1);
    end
  end

  always_ff @(posedge clk125) begin
    if (push) obuf[wr_ptr] <= push_word;
  end

  ////////////////////////////////////////////////////////////
  // readout FSM and counters
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      state     <= RD_IDLE;
      pause_s1  <= 1'b0;
      pause_s2  <= 1'b0;
      done_q    <= 1'b0;
      fill_cnt  <= '0;
      issue_cnt <= '0;
      recv_cnt  <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      count     <= '0;
      inflight  <= '0;
    end else begin
      pause_s1 <= readout_pause;
      pause_s2 <= pause_s1;
      done_q   <= acq_done;
      if (acq_done && !done_q) fill_cnt <= fill_cnt + 20'd1;  // one per finished capture
      case (state)
        RD_IDLE: begin
          if (readout_start && acq_done) begin
            state     <= RD_HEADER;
            issue_cnt <= '0;
            recv_cnt  <= '0;
          end
        end
        RD_HEADER: state <= RD_DATA;             // header pushed this cycle
        default: begin
          if (pop && tx.tlast) state <= RD_IDLE;
        end
      endcase
      if (rd_req && rd_gnt) issue_cnt <= issue_cnt + 16'd1;
      if (rd_rvalid) recv_cnt <= recv_cnt + 16'd1;
      inflight <= inflight + 2'(rd_req && rd_gnt) - 2'(rd_rvalid);
      count    <= count + 2'(push) - 2'(pop);
      if (push) wr_ptr <= !wr_ptr;
      if (pop) rd_ptr <= !rd_ptr;
    end
  end

endmodule

/* design/wfd_mem_arbiter.sv */
module wfd_mem_arbiter #(
  parameter int MEM_AW = 10
) (
  input  logic              clk125,
  input  logic              rst_n,
  input  logic              wr_req,
  input  logic [MEM_AW-1:0] wr_addr,
  input  wfd_pkg::word_t    wr_data,
  input  logic              rd_req,
  input  logic [MEM_AW-1:0] rd_addr,
  input  logic              peek_req,
  input  logic [MEM_AW-1:0] peek_addr,
  output logic              wr_gnt,
  output logic              rd_gnt,
  output logic              rd_rvalid,
  output wfd_pkg::word_t    rd_rdata,
  output logic              peek_gnt,
  output logic              peek_rvalid,
  output wfd_pkg::word_t    peek_rdata
);

  wfd_pkg::word_t    mem [2**MEM_AW];
  wfd_pkg::word_t    rdata_q;
  logic [MEM_AW-1:0] raddr;

  ////////////////////////////////////////////////////////////
  // fixed priority, acq > readout > peek
  assign wr_gnt   = wr_req;
  assign rd_gnt   = rd_req && !wr_req;
  assign peek_gnt = peek_req && !wr_req && !rd_req;
  assign raddr    = rd_gnt ? rd_addr : peek_addr;

  always_ff @(posedge clk125) begin
    if (wr_gnt) mem[wr_addr] <= wr_data;
    if (rd_gnt || peek_gnt) rdata_q <= mem[raddr];   // one read per cycle
  end

  // route the response back to the granted port only
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      rd_rvalid   <= 1'b0;
      peek_rvalid <= 1'b0;
    end else begin
      rd_rvalid   <= rd_gnt;
      peek_rvalid <= peek_gnt;
    end
  end

  assign rd_rdata   = rdata_q;
  assign peek_rdata = rdata_q;

endmodule

/* design/wfd_channel_top.sv */
module wfd_channel_top #(
  parameter int MEM_AW = 10
) (
  input  logic               clk125,
  input  logic               rst_n,
  input  wfd_pkg::axil_req_t axil_req,
  input  logic               acq_trig,
  input  wfd_pkg::sample_t   adc_sample,
  input  logic               adc_ovr,
  input  logic               readout_pause,
  input  logic               tx_tready,
  output wfd_pkg::axil_rsp_t axil_rsp,
  output logic               acq_done,
  output wfd_pkg::stream_t   tx,
  output logic               tx_tvalid
);

  wfd_pkg::acq_cfg_t    acq_cfg;       // regs to acq and readout
  wfd_pkg::acq_status_t acq_status;
  logic                 readout_start;
  logic                 readout_busy;
  logic                 peek_req, peek_gnt, peek_rvalid;
  logic [MEM_AW-1:0]    peek_addr;
  wfd_pkg::word_t       peek_rdata;
  logic                 wr_req, wr_gnt;
  logic [MEM_AW-1:0]    wr_addr;
  wfd_pkg::word_t       wr_data;
  logic                 rd_req, rd_gnt, rd_rvalid;
  logic [MEM_AW-1:0]    rd_addr;
  wfd_pkg::word_t       rd_rdata;

  ////////////////////////////////////////////////////////////
  wfd_regs #(.MEM_AW(MEM_AW)) wfd_regs_i (
    .clk125, .rst_n, .axil_req, .acq_status, .readout_busy,
    .peek_gnt, .peek_rvalid, .peek_rdata,
    .axil_rsp, .acq_cfg, .readout_start, .peek_req, .peek_addr
  );

  wfd_acq #(.MEM_AW(MEM_AW)) wfd_acq_i (
    .clk125, .rst_n, .acq_cfg, .readout_busy, .acq_trig, .adc_sample, .adc_ovr,
    .wr_gnt, .acq_status, .acq_done, .wr_req, .wr_addr, .wr_data
  );

  wfd_readout #(.MEM_AW(MEM_AW)) wfd_readout_i (
    .clk125, .rst_n, .acq_cfg, .acq_done, .readout_start, .readout_pause,
    .rd_gnt, .rd_rvalid, .rd_rdata, .tx_tready,
    .readout_busy, .rd_req, .rd_addr, .tx, .tx_tvalid
  );

  wfd_mem_arbiter #(.MEM_AW(MEM_AW)) wfd_mem_arbiter_i (
    .clk125, .rst_n,
    .wr_req, .wr_addr, .wr_data,        // acq port, top priority
    .rd_req, .rd_addr,                  // stream readout
    .peek_req, .peek_addr,              // register peek, lowest
    .wr_gnt, .rd_gnt, .rd_rvalid, .rd_rdata,
    .peek_gnt, .peek_rvalid, .peek_rdata
  );

endmodule

/* dv/wfd_stream_checker.sv */
module wfd_stream_checker (
  input logic                 clk125,
  input logic                 rst_n,
  input wfd_pkg::stream_t     tx,
  input logic                 tx_tvalid,
  input logic                 tx_tready,
  input logic                 readout_pause,
  input logic                 acq_done,
  input wfd_pkg::acq_status_t acq_status
);

  int unsigned fails = 0;   // failed assertions so far
  logic        pause_s1;
  logic        pause_s2;    // own copy of the two-stage pause sync

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      pause_s1 <= 1'b0;
      pause_s2 <= 1'b0;
    end else begin
      pause_s1 <= readout_pause;
      pause_s2 <= pause_s1;
    end
  end

  ////////////////////////////////////////////////////////////
  // stream rules
  tvalid_in_reset: assert property (@(posedge clk125) !rst_n |=> !tx_tvalid)
    else begin
      fails++;
      $error("tvalid high after a reset cycle");
    end

  stable_when_stalled: assert property (@(posedge clk125) disable iff (!rst_n)
    (tx_tvalid && !tx_tready) |=> $stable(tx))
    else begin
      fails++;
      $error("tdata or tlast moved while stalled");
    end

  quiet_when_paused: assert property (@(posedge clk125) disable iff (!rst_n)
    pause_s2 |-> !tx_tvalid)
    else begin
      fails++;
      $error("tvalid high during pause");
    end

  // capture and done are exclusive
  done_not_capturing: assert property (@(posedge clk125) disable iff (!rst_n)
    !(acq_done && acq_status.capturing))
    else begin
      fails++;
      $error("acq_done and capturing both high");
    end

endmodule

/* dv/wfd_tb.sv */
module wfd_tb;

  localparam int MEM_AW     = 6;
  localparam int WAIT_LIMIT = 200;   // cycles for one handshake

  logic                 clk125;
  logic                 rst_n;
  wfd_pkg::axil_req_t   axil_req;
  wfd_pkg::axil_rsp_t   axil_rsp;
  logic                 acq_trig;
  wfd_pkg::sample_t     adc_sample;
  logic                 adc_ovr;
  logic                 readout_pause;
  logic                 tx_tready;
  logic                 acq_done;
  wfd_pkg::stream_t     tx;
  logic                 tx_tvalid;

  logic                 hold_pause;          // forces pause high on top of the random one
  int                   edge_cnt;            // rising edges seen so far
  logic [31:0]          rnd_state;
  logic [12:0]          sample_at [65536];   // tagged sample present at each edge
  wfd_pkg::word_t       model_mem [64];      // expected memory contents
  wfd_pkg::fill_num_t   fill_model;          // expected fill_num

  wfd_channel_top #(.MEM_AW(MEM_AW)) wfd_channel_top_i (
    .clk125, .rst_n, .axil_req, .acq_trig, .adc_sample, .adc_ovr,
    .readout_pause, .tx_tready, .axil_rsp, .acq_done, .tx, .tx_tvalid
  );

  bind wfd_channel_top wfd_stream_checker stream_checker_i (
    .clk125(clk125), .rst_n(rst_n), .tx(tx), .tx_tvalid(tx_tvalid),
    .tx_tready(tx_tready), .readout_pause(readout_pause),
    .acq_done(acq_done), .acq_status(acq_status)
  );

  initial begin
    clk125 = 1'b0;
    forever #10 clk125 = ~clk125;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////
  // free-running adc, tready and pause stimulus
  initial begin
    edge_cnt      = 0;
    rnd_state     = 32'd56315;
    adc_sample    = '0;
    adc_ovr       = 1'b0;
    tx_tready     = 1'b0;
    readout_pause = 1'b0;
    forever begin
      @(posedge clk125);
      edge_cnt = edge_cnt + 1;
      #1;
      rnd_state     = xorshift32(rnd_state);
      adc_sample    = rnd_state[11:0];
      adc_ovr       = rnd_state[12];
      tx_tready     = rnd_state[20] | rnd_state[21];                   // ~75% ready
      readout_pause = hold_pause | (rnd_state[26:24] == 3'd0);        // ~1 in 8
      sample_at[16'(edge_cnt + 1)] = {rnd_state[12], rnd_state[11:0]}; // seen at next edge
    end
  end

  ////////////////////////////////////////////////////////////
  // reporting
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input wfd_pkg::word_t exp,
                             input wfd_pkg::word_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  // stop at the first failed stream assertion
  always @(negedge clk125) begin
    if (wfd_channel_top_i.stream_checker_i.fails != 0) begin
      abort_run("a stream assertion failed");
    end
  end

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(posedge clk125);
    #1;
    rst_n      = 1'b1;
    fill_model = '0;                                 // counter restarts at reset
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite host tasks start and end just after a rising edge
  task automatic reg_write(input wfd_pkg::axil_addr_t addr, input wfd_pkg::word_t data);
    int n;
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    n = 0;
    while (!axil_rsp.awready && n < WAIT_LIMIT) begin
      @(negedge clk125);
      n++;
    end
    if (!axil_rsp.awready) abort_run("write address was never accepted");
    check_value("wready with awready", 32'd1, 32'(axil_rsp.wready));
    @(posedge clk125);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    while (!axil_rsp.bvalid && n < WAIT_LIMIT) begin
      @(negedge clk125);
      n++;
    end
    if (!axil_rsp.bvalid) abort_run("write response never came back");
    check_value("bresp OKAY", 32'd0, 32'(axil_rsp.bresp));
    @(posedge clk125);                               // bready is held high
    #1;
  endtask

  task automatic reg_read(input wfd_pkg::axil_addr_t addr, output wfd_pkg::word_t data);
    int n;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    n = 0;
    while (!axil_rsp.arready && n < WAIT_LIMIT) begin
      @(negedge clk125);
      n++;
    end
    if (!axil_rsp.arready) abort_run("read address was never accepted");
    @(posedge clk125);
    #1;
    axil_req.arvalid = 1'b0;
    n = 0;
    while (!axil_rsp.rvalid && n < WAIT_LIMIT) begin
      @(negedge clk125);
      n++;
    end
    if (!axil_rsp.rvalid) abort_run("read data never came back");
    check_value("rresp OKAY", 32'd0, 32'(axil_rsp.rresp));
    data = axil_rsp.rdata;
    @(posedge clk125);                               // rready is held high
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk125);
    #1;
  endtask

  task automatic status_check(input wfd_pkg::fill_num_t fill, input logic done,
                              input logic busy);
    wfd_pkg::word_t v;
    reg_read(wfd_pkg::REG_STATUS, v);
    check_value("status fill_num", 32'(fill), 32'(v[31:12]));
    check_value("status acq_done", 32'(done), 32'(v[1]));
    check_value("status readout busy", 32'(busy), 32'(v[2]));
    check_value("status capturing", 32'd0, 32'(v[0]));
  endtask

  ////////////////////////////////////////////////////////////
  // acquisition and readout
  task automatic pulse_trigger(output int te);
    acq_trig = 1'b1;
    te       = edge_cnt + 1;                         // edge that sees the rise
    @(posedge clk125);
    #1;
    acq_trig = 1'b0;
  endtask

  task automatic capture_waveform(input int nw);
    int te;
    int n;
    pulse_trigger(te);
    n = 0;
    while (!acq_done && n < 2 * nw + 20) begin
      @(negedge clk125);
      n++;
    end
    if (!acq_done) abort_run("acq_done did not rise after an armed trigger");
    @(posedge clk125);
    #1;
    fill_model = fill_model + 20'd1;
    for (int k = 0; k < nw; k++) begin           // odd sample above even one
      model_mem[6'(k)] = {fill_model[5:0], sample_at[16'(te + 2 * k + 1)],
                          sample_at[16'(te + 2 * k)]};
    end
    status_check(fill_model, 1'b1, 1'b0);
  endtask

  task automatic peek_check(input int nw);
    wfd_pkg::word_t v;
    for (int a = 0; a < nw; a++) begin
      reg_write(wfd_pkg::REG_PEEK_ADDR, 32'(a));
      reg_read(wfd_pkg::REG_PEEK_DATA, v);
      check_value($sformatf("peek word %0d", a), model_mem[6'(a)], v);
    end
  endtask

  task automatic stream_check(input int nw, input wfd_pkg::fill_num_t fill,
                              input wfd_pkg::chan_tag_t tag);
    wfd_pkg::word_t exp;
    int got;
    int n;
    got = 0;
    n   = 0;
    while (got < nw + 1 && n < 20 * nw + 100) begin
      @(negedge clk125);
      n++;
      if (tx_tvalid && tx_tready) begin          // taken at the coming edge
        exp = (got == 0) ? {tag, fill} : model_mem[6'(got - 1)];
        check_value($sformatf("stream word %0d", got), exp, tx.tdata);
        check_value($sformatf("tlast of word %0d", got), 32'(got == nw), 32'(tx.tlast));
        got++;
      end
    end
    if (got < nw + 1) abort_run("stream stopped before the last word");
    @(posedge clk125);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    wfd_pkg::word_t v;
    int te;
    int nw;
    rst_n            = 1'b0;
    acq_trig         = 1'b0;
    hold_pause       = 1'b0;
    axil_req         = '0;
    axil_req.bready  = 1'b1;
    axil_req.rready  = 1'b1;
    fill_model       = '0;
    apply_reset();

    // start with nothing captured
    reg_write(wfd_pkg::REG_CTRL, 32'h2);
    for (int i = 0; i < 40; i++) begin
      @(negedge clk125);
      if (tx_tvalid) abort_run("tvalid rose after a readout start with no capture");
    end
    @(posedge clk125);
    #1;
    status_check(20'd0, 1'b0, 1'b0);

    // register access
    reg_write(wfd_pkg::REG_NUM_WORDS, 32'd12);
    reg_read(wfd_pkg::REG_NUM_WORDS, v);
    check_value("num_words readback", 32'd12, v);
    reg_write(wfd_pkg::REG_CHAN_TAG, 32'h5A3);
    reg_read(wfd_pkg::REG_CHAN_TAG, v);
    check_value("channel tag readback", 32'h5A3, v);
    reg_read(8'h1C, v);
    check_value("unmapped 0x1C", 32'd0, v);
    reg_read(8'h3C, v);
    check_value("unmapped 0x3C", 32'd0, v);

    // capture, peek, stream
    reg_write(wfd_pkg::REG_CTRL, 32'h1);
    capture_waveform(12);
    peek_check(12);
    reg_write(wfd_pkg::REG_CTRL, 32'h3);
    stream_check(12, fill_model, 12'h5A3);
    status_check(fill_model, 1'b1, 1'b0);

    // trigger filtering
    reg_write(wfd_pkg::REG_CTRL, 32'h0);           // disarmed
    pulse_trigger(te);
    idle_cycles(20);
    status_check(fill_model, 1'b1, 1'b0);
    acq_trig = 1'b1;                               // held high from before arm so no edge follows
    idle_cycles(5);
    reg_write(wfd_pkg::REG_CTRL, 32'h1);
    idle_cycles(20);
    status_check(fill_model, 1'b1, 1'b0);
    acq_trig = 1'b0;
    idle_cycles(2);
    hold_pause = 1'b1;                             // keeps readout busy
    reg_write(wfd_pkg::REG_CTRL, 32'h3);
    idle_cycles(10);
    status_check(fill_model, 1'b1, 1'b1);
    pulse_trigger(te);
    idle_cycles(20);
    status_check(fill_model, 1'b1, 1'b1);
    hold_pause = 1'b0;
    stream_check(12, fill_model, 12'h5A3);
    peek_check(12);

    // fill numbering from a fresh reset
    apply_reset();
    reg_write(wfd_pkg::REG_CHAN_TAG, 32'h3C7);
    reg_write(wfd_pkg::REG_CTRL, 32'h1);
    for (int f = 1; f <= 3; f++) begin
      nw = (f == 1) ? 5 : (f == 2) ? 23 : 64;      // 64 fills the memory
      reg_write(wfd_pkg::REG_NUM_WORDS, 32'(nw));
      capture_waveform(nw);
      reg_write(wfd_pkg::REG_CTRL, 32'h3);
      stream_check(nw, 20'(f), 12'h3C7);
      status_check(20'(f), 1'b1, 1'b0);
    end

    if (wfd_channel_top_i.stream_checker_i.fails == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("stream assertions failed %0d times",
               wfd_channel_top_i.stream_checker_i.fails);
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

/* vlog.f */
design/wfd_pkg.sv
design/wfd_regs.sv
design/wfd_acq.sv
design/wfd_readout.sv
design/wfd_mem_arbiter.sv
design/wfd_channel_top.sv
dv/wfd_stream_checker.sv
dv/wfd_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wfd_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
